//--- hw/cpu_pkg.sv
package cpu_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int DATA_W    = 16;
    localparam int BYTE_W    = 8;
    localparam int ADDR_W    = 16;
    localparam int PORT_W    = 16;
    localparam int REG_IDX_W = 3;
    localparam int FLAGS_W   = 12;

    localparam logic [ADDR_W-1:0] RESET_IP = 16'h0000;   // First fetch address

    // Register numbers, byte view is AL CL DL BL AH CH DH BH
    localparam logic [REG_IDX_W-1:0] REG_AX = 3'd0;
    localparam logic [REG_IDX_W-1:0] REG_CX = 3'd1;
    localparam logic [REG_IDX_W-1:0] REG_DX = 3'd2;
    localparam logic [REG_IDX_W-1:0] REG_BX = 3'd3;
    localparam logic [REG_IDX_W-1:0] REG_SP = 3'd4;
    localparam logic [REG_IDX_W-1:0] REG_BP = 3'd5;
    localparam logic [REG_IDX_W-1:0] REG_SI = 3'd6;
    localparam logic [REG_IDX_W-1:0] REG_DI = 3'd7;

    // Flag bit positions, 8086 layout
    localparam logic [3:0] CF = 4'd0;
    localparam logic [3:0] PF = 4'd2;
    localparam logic [3:0] AF = 4'd4;
    localparam logic [3:0] ZF = 4'd6;
    localparam logic [3:0] SF = 4'd7;
    localparam logic [3:0] OF = 4'd11;

    // Same order as opcode bits 5:3
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_OR  = 3'd1,
        ALU_ADC = 3'd2,
        ALU_SBB = 3'd3,
        ALU_AND = 3'd4,
        ALU_SUB = 3'd5,
        ALU_XOR = 3'd6,
        ALU_CMP = 3'd7
    } alu_op_e;

    typedef enum logic [2:0] {
        ST_OPCODE,
        ST_MODRM,
        ST_IMM_LO,
        ST_IMM_HI,
        ST_EXEC,
        ST_OUT_HI,
        ST_HALT
    } state_e;

endpackage

//--- hw/cpu_alu.sv
`timescale 1ns/1ps

module cpu_alu (
    input  cpu_pkg::alu_op_e                 i_op,
    input  logic                             i_word,
    input  logic [cpu_pkg::DATA_W-1:0]       i_a,
    input  logic [cpu_pkg::DATA_W-1:0]       i_b,
    input  logic [cpu_pkg::FLAGS_W-1:0]      i_flags,
    output logic [cpu_pkg::DATA_W-1:0]       o_result,
    output logic [cpu_pkg::FLAGS_W-1:0]      o_flags
);

    logic [cpu_pkg::DATA_W-1:0] a, b;
    logic [cpu_pkg::DATA_W:0]   r;          // One extra bit for carry out
    logic                       msb_a, msb_b, msb_r, carry;
    logic                       is_logic, is_sub;

    always_comb begin
        a = i_word ? i_a : {8'h00, i_a[7:0]};
        b = i_word ? i_b : {8'h00, i_b[7:0]};
        is_logic = 1'b0;
        is_sub   = 1'b0;
        case (i_op)
            cpu_pkg::ALU_ADD: r = {1'b0, a} + {1'b0, b};
            cpu_pkg::ALU_ADC: r = {1'b0, a} + {1'b0, b} + i_flags[cpu_pkg::CF];
            cpu_pkg::ALU_SBB: begin
                r      = {1'b0, a} - {1'b0, b} - i_flags[cpu_pkg::CF];
                is_sub = 1'b1;
            end
            cpu_pkg::ALU_SUB,
            cpu_pkg::ALU_CMP: begin
                r      = {1'b0, a} - {1'b0, b};
                is_sub = 1'b1;
            end
            cpu_pkg::ALU_AND: begin r = {1'b0, a & b}; is_logic = 1'b1; end
            cpu_pkg::ALU_OR:  begin r = {1'b0, a | b}; is_logic = 1'b1; end
            default:          begin r = {1'b0, a ^ b}; is_logic = 1'b1; end   // XOR
        endcase

        // Sign bits and carry at the active width
        msb_a = i_word ? a[15] : a[7];
        msb_b = i_word ? b[15] : b[7];
        msb_r = i_word ? r[15] : r[7];
        carry = i_word ? r[16] : r[8];   // Borrow shows up here too
        o_result = i_word ? r[15:0] : {8'h00, r[7:0]};

        o_flags = i_flags;
        if (is_logic) begin
            o_flags[cpu_pkg::CF] = 1'b0;
            o_flags[cpu_pkg::OF] = 1'b0;
        end else begin
            o_flags[cpu_pkg::CF] = carry;
            o_flags[cpu_pkg::AF] = a[4] ^ b[4] ^ r[4];
            o_flags[cpu_pkg::OF] = is_sub ? (msb_a ^ msb_b) & (msb_a ^ msb_r)
                                          : ~(msb_a ^ msb_b) & (msb_a ^ msb_r);
        end
        o_flags[cpu_pkg::SF] = msb_r;
        o_flags[cpu_pkg::ZF] = o_result == '0;
        o_flags[cpu_pkg::PF] = ~^r[7:0];    // Even parity of low byte
    end

endmodule

//--- hw/cpu_regfile.sv
`timescale 1ns/1ps

module cpu_regfile (
    input  logic                             clock,
    input  logic                             i_rst,
    input  logic [cpu_pkg::REG_IDX_W-1:0]    i_rd_a_idx,
    input  logic [cpu_pkg::REG_IDX_W-1:0]    i_rd_b_idx,
    input  logic                             i_word,
    output logic [cpu_pkg::DATA_W-1:0]       o_rd_a,
    output logic [cpu_pkg::DATA_W-1:0]       o_rd_b,
    input  logic                             i_wr_en,
    input  logic [cpu_pkg::REG_IDX_W-1:0]    i_wr_idx,
    input  logic [cpu_pkg::DATA_W-1:0]       i_wr_data
);

    localparam int NUM_REGS = 1 << cpu_pkg::REG_IDX_W;

    logic [cpu_pkg::DATA_W-1:0] regs [NUM_REGS];

    // Byte view maps 4..7 onto the high half of 0..3
    function automatic logic [cpu_pkg::DATA_W-1:0] read_reg(
        input logic [cpu_pkg::REG_IDX_W-1:0] idx,
        input logic                          word
    );
        logic [cpu_pkg::DATA_W-1:0] base;
        base = regs[{1'b0, idx[1:0]}];
        if (word) return regs[idx];
        return idx[2] ? {8'h00, base[15:8]} : {8'h00, base[7:0]};
    endfunction

    always_comb begin
        o_rd_a = read_reg(i_rd_a_idx, i_word);
        o_rd_b = read_reg(i_rd_b_idx, i_word);
    end

    always_ff @(posedge clock) begin
        if (i_rst) begin
            for (int i = 0; i < NUM_REGS; i++) regs[i] <= '0;
        end else if (i_wr_en) begin
            if (i_word) regs[i_wr_idx] <= i_wr_data;
            else if (i_wr_idx[2]) regs[{1'b0, i_wr_idx[1:0]}][15:8] <= i_wr_data[7:0];  // AH..BH
            else regs[{1'b0, i_wr_idx[1:0]}][7:0] <= i_wr_data[7:0];
        end
    end

endmodule

//--- hw/cpu_control.sv
`timescale 1ns/1ps

module cpu_control (
    input  logic                             clock,
    input  logic                             i_rst,
    input  logic [cpu_pkg::BYTE_W-1:0]       i_data,
    output logic [cpu_pkg::ADDR_W-1:0]       o_address,
    output logic [cpu_pkg::PORT_W-1:0]       o_port_address,
    output logic [cpu_pkg::BYTE_W-1:0]       o_port_data,
    output logic                             o_port_write,
    output logic                             o_halted,
    output logic [cpu_pkg::REG_IDX_W-1:0]    o_rd_a_idx,
    output logic [cpu_pkg::REG_IDX_W-1:0]    o_rd_b_idx,
    output logic                             o_word,
    input  logic [cpu_pkg::DATA_W-1:0]       i_rd_a,
    input  logic [cpu_pkg::DATA_W-1:0]       i_rd_b,
    output logic                             o_wr_en,
    output logic [cpu_pkg::REG_IDX_W-1:0]    o_wr_idx,
    output logic [cpu_pkg::DATA_W-1:0]       o_wr_data,
    output cpu_pkg::alu_op_e                 o_alu_op,
    output logic [cpu_pkg::DATA_W-1:0]       o_alu_a,
    output logic [cpu_pkg::DATA_W-1:0]       o_alu_b,
    output logic [cpu_pkg::FLAGS_W-1:0]      o_flags,
    input  logic [cpu_pkg::DATA_W-1:0]       i_alu_result,
    input  logic [cpu_pkg::FLAGS_W-1:0]      i_alu_flags
);

    cpu_pkg::state_e               state;
    logic [cpu_pkg::ADDR_W-1:0]    ip;
    logic [cpu_pkg::FLAGS_W-1:0]   flags;
    logic [cpu_pkg::BYTE_W-1:0]    opcode;
    logic [cpu_pkg::BYTE_W-1:0]    modrm;
    logic [cpu_pkg::BYTE_W-1:0]    imm_lo;
    logic [cpu_pkg::DATA_W-1:0]    imm_word;
    logic [cpu_pkg::FLAGS_W-1:0]   incdec_flags;
    logic [cpu_pkg::ADDR_W-1:0]    jump_target;
    logic [7:0]                    branches;
    logic                          take_branch;
    logic                          is_alu_rm, is_alu_imm, is_mov, is_incdec, is_out;
    logic                          is_cmp;

    // Opcode classes of the latched opcode
    assign is_alu_rm  = (opcode[7:6] == 2'b00) && !opcode[2];          // 00xxx0dw
    assign is_alu_imm = (opcode[7:6] == 2'b00) && (opcode[2:1] == 2'b10);
    assign is_mov     = opcode[7:4] == 4'b1011;
    assign is_incdec  = opcode[7:4] == 4'b0100;
    assign is_out     = (opcode[7:4] == 4'b1110) && (opcode[2:1] == 2'b11);
    assign is_cmp     = o_alu_op == cpu_pkg::ALU_CMP;

    // Jcc conditions by opcode[3:1], opcode[0] inverts
    assign branches = {
        (flags[cpu_pkg::SF] ^ flags[cpu_pkg::OF]) | flags[cpu_pkg::ZF],  // JLE
        flags[cpu_pkg::SF] ^ flags[cpu_pkg::OF],                         // JL
        flags[cpu_pkg::PF],
        flags[cpu_pkg::SF],
        flags[cpu_pkg::CF] | flags[cpu_pkg::ZF],                         // JBE
        flags[cpu_pkg::ZF],
        flags[cpu_pkg::CF],
        flags[cpu_pkg::OF]
    };
    assign take_branch = (opcode == 8'hEB) || (branches[opcode[3:1]] ^ opcode[0]);
    assign jump_target = ip + 16'd1 + {{8{i_data[7]}}, i_data};   // ip still on disp byte

    assign o_address = ip;
    assign o_flags   = flags;
    assign o_alu_a   = i_rd_a;
    assign o_halted  = state == cpu_pkg::ST_HALT;

    // --------------------------------------------------
    // Operand select and write-back
    // --------------------------------------------------
    always_comb begin
        imm_word     = {i_data, imm_lo};
        incdec_flags = i_alu_flags;
        incdec_flags[cpu_pkg::CF] = flags[cpu_pkg::CF];   // INC/DEC keep CF
        o_word     = opcode[0];
        o_rd_a_idx = cpu_pkg::REG_AX;                     // AL/AX for imm form and OUT
        o_rd_b_idx = cpu_pkg::REG_DX;                     // Port for OUT DX
        o_alu_op   = cpu_pkg::alu_op_e'(opcode[5:3]);
        o_alu_b    = opcode[0] ? imm_word : {8'h00, i_data};
        if (is_alu_rm) begin
            // d bit selects reg field as destination
            o_rd_a_idx = opcode[1] ? modrm[5:3] : modrm[2:0];
            o_rd_b_idx = opcode[1] ? modrm[2:0] : modrm[5:3];
            o_alu_b    = i_rd_b;
        end else if (is_mov) begin
            o_word     = opcode[3];
            o_rd_a_idx = opcode[2:0];
        end else if (is_incdec) begin
            o_word     = 1'b1;
            o_rd_a_idx = opcode[2:0];
            o_alu_op   = opcode[3] ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
            o_alu_b    = 16'd1;
        end else if (is_out) begin
            o_word     = 1'b1;
        end
        o_wr_idx  = o_rd_a_idx;
        o_wr_data = is_mov ? (o_word ? imm_word : {8'h00, i_data}) : i_alu_result;
        case (state)
            cpu_pkg::ST_IMM_LO: o_wr_en = (is_mov && !opcode[3]) ||
                                          (is_alu_imm && !opcode[0] && !is_cmp);
            cpu_pkg::ST_IMM_HI: o_wr_en = is_mov || (is_alu_imm && !is_cmp);
            cpu_pkg::ST_EXEC:   o_wr_en = is_incdec || (is_alu_rm && !is_cmp);
            default:            o_wr_en = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // Sequencer
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        o_port_write <= 1'b0;
        if (i_rst) begin
            state  <= cpu_pkg::ST_OPCODE;
            ip     <= cpu_pkg::RESET_IP;
            flags  <= '0;
            opcode <= '0;
        end else begin
            case (state)
                cpu_pkg::ST_OPCODE: begin
                    opcode <= i_data;
                    ip     <= ip + 1'b1;
                    casez (i_data)
                        8'b00???0??: state <= cpu_pkg::ST_MODRM;    // ALU r/m, r
                        8'b00???10?,                                // ALU acc, imm
                        8'b1011????,                                // MOV r, imm
                        8'b0111????,                                // Jcc
                        8'b11101011,                                // JMP short
                        8'b1110011?: state <= cpu_pkg::ST_IMM_LO;   // OUT imm8
                        8'b0100????,                                // INC/DEC r16
                        8'b1111100?,                                // CLC/STC
                        8'b1110111?: state <= cpu_pkg::ST_EXEC;     // OUT DX
                        default:     state <= cpu_pkg::ST_HALT;     // HLT or unknown
                    endcase
                end
                cpu_pkg::ST_MODRM: begin
                    modrm <= i_data;
                    ip    <= ip + 1'b1;
                    // Memory operands are not supported
                    state <= (i_data[7:6] == 2'b11) ? cpu_pkg::ST_EXEC : cpu_pkg::ST_HALT;
                end
                cpu_pkg::ST_IMM_LO: begin
                    imm_lo <= i_data;
                    ip     <= ip + 1'b1;
                    state  <= cpu_pkg::ST_OPCODE;
                    if (is_mov) begin
                        if (opcode[3]) state <= cpu_pkg::ST_IMM_HI;
                    end else if (is_alu_imm) begin
                        if (opcode[0]) state <= cpu_pkg::ST_IMM_HI;
                        else flags <= i_alu_flags;
                    end else if (is_out) begin
                        o_port_address <= {8'h00, i_data};
                        o_port_data    <= i_rd_a[7:0];
                        o_port_write   <= 1'b1;
                        if (opcode[0]) state <= cpu_pkg::ST_OUT_HI;
                    end else if (take_branch) begin
                        ip <= jump_target;
                    end
                end
                cpu_pkg::ST_IMM_HI: begin
                    ip    <= ip + 1'b1;
                    state <= cpu_pkg::ST_OPCODE;
                    if (is_alu_imm) flags <= i_alu_flags;
                end
                cpu_pkg::ST_EXEC: begin
                    state <= cpu_pkg::ST_OPCODE;
                    if (is_alu_rm) begin
                        flags <= i_alu_flags;
                    end else if (is_incdec) begin
                        flags <= incdec_flags;
                    end else if (is_out) begin
                        o_port_address <= i_rd_b;
                        o_port_data    <= i_rd_a[7:0];
                        o_port_write   <= 1'b1;
                        if (opcode[0]) state <= cpu_pkg::ST_OUT_HI;
                    end else begin
                        flags[cpu_pkg::CF] <= opcode[0];     // CLC / STC
                    end
                end
                cpu_pkg::ST_OUT_HI: begin
                    o_port_address <= o_port_address + 1'b1;  // AH goes to port+1
                    o_port_data    <= i_rd_a[15:8];
                    o_port_write   <= 1'b1;
                    state          <= cpu_pkg::ST_OPCODE;
                end
                default: state <= cpu_pkg::ST_HALT;           // Halted for good
            endcase
        end
    end

endmodule

//--- hw/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic                          clock,
    input  logic                          i_rst,
    input  logic [cpu_pkg::BYTE_W-1:0]    i_data,          // Program byte at o_address
    output logic [cpu_pkg::ADDR_W-1:0]    o_address,
    output logic [cpu_pkg::PORT_W-1:0]    o_port_address,
    output logic [cpu_pkg::BYTE_W-1:0]    o_port_data,
    output logic                          o_port_write,
    output logic                          o_halted
);

    logic [cpu_pkg::REG_IDX_W-1:0] rd_a_idx;
    logic [cpu_pkg::REG_IDX_W-1:0] rd_b_idx;
    logic [cpu_pkg::REG_IDX_W-1:0] wr_idx;
    logic [cpu_pkg::DATA_W-1:0]    rd_a;
    logic [cpu_pkg::DATA_W-1:0]    rd_b;
    logic [cpu_pkg::DATA_W-1:0]    wr_data;
    logic                          word;
    logic                          wr_en;
    cpu_pkg::alu_op_e              alu_op;
    logic [cpu_pkg::DATA_W-1:0]    alu_a;
    logic [cpu_pkg::DATA_W-1:0]    alu_b;
    logic [cpu_pkg::DATA_W-1:0]    alu_result;
    logic [cpu_pkg::FLAGS_W-1:0]   flags;
    logic [cpu_pkg::FLAGS_W-1:0]   alu_flags;

    cpu_control cpu_control_inst (
        .clock(clock), .i_rst(i_rst), .i_data(i_data), .o_address(o_address),
        .o_port_address(o_port_address), .o_port_data(o_port_data),
        .o_port_write(o_port_write), .o_halted(o_halted),
        .o_rd_a_idx(rd_a_idx), .o_rd_b_idx(rd_b_idx), .o_word(word),
        .i_rd_a(rd_a), .i_rd_b(rd_b), .o_wr_en(wr_en), .o_wr_idx(wr_idx),
        .o_wr_data(wr_data), .o_alu_op(alu_op), .o_alu_a(alu_a), .o_alu_b(alu_b),
        .o_flags(flags), .i_alu_result(alu_result), .i_alu_flags(alu_flags)
    );

    cpu_regfile cpu_regfile_inst (
        .clock(clock), .i_rst(i_rst), .i_rd_a_idx(rd_a_idx), .i_rd_b_idx(rd_b_idx),
        .i_word(word), .o_rd_a(rd_a), .o_rd_b(rd_b), .i_wr_en(wr_en),
        .i_wr_idx(wr_idx), .i_wr_data(wr_data)
    );

    cpu_alu cpu_alu_inst (
        .i_op(alu_op), .i_word(word), .i_a(alu_a), .i_b(alu_b), .i_flags(flags),
        .o_result(alu_result), .o_flags(alu_flags)
    );

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic o_clock
);

    initial begin
        o_clock = 1'b0;
    end

    always #10 o_clock = ~o_clock;   // 20 ns period

endmodule

//--- sim/cpu_sva.sv
`timescale 1ns/1ps

module cpu_sva (
    input logic                          clock,
    input logic                          i_rst,
    input logic [cpu_pkg::ADDR_W-1:0]    o_address,
    input logic [cpu_pkg::PORT_W-1:0]    o_port_address,
    input logic                          o_port_write,
    input logic                          o_halted
);

    // First fetch at reset IP, quiet outputs
    a_reset_state: assert property (@(posedge clock)
        i_rst |=> (o_address == cpu_pkg::RESET_IP) && !o_port_write && !o_halted)
        else $error("Outputs not idle after reset");

    // Back to back strobes only for the AH half of an AX write
    a_strobe_pair: assert property (@(posedge clock) disable iff (i_rst)
        o_port_write && $past(o_port_write) |->
            (o_port_address == $past(o_port_address) + 16'd1) && !$past(o_port_write, 2))
        else $error("Port strobe held for more than one write");

    a_halt_sticky: assert property (@(posedge clock) disable iff (i_rst)
        o_halted |=> o_halted)
        else $error("Halt dropped without reset");

    a_halt_frozen: assert property (@(posedge clock) disable iff (i_rst)
        o_halted |=> $stable(o_address) && !o_port_write)
        else $error("Core active while halted");

endmodule

//--- sim/tb_program.svh
// Jcc that picks OUT to port 41h when taken and 40h when not
task automatic jcc_block(input logic [3:0] cc);
    put(8'h70 | {4'h0, cc});
    put(8'h04);
    put(8'hE6); put(8'h40);   // Not taken
    put(8'hEB); put(8'h02);
    put(8'hE6); put(8'h41);   // Taken
    expect_write(cond_true(cc, flags) ? 16'h0041 : 16'h0040, ax[7:0]);
endtask

// ALU byte ops on AL with CL and then with an immediate under a random carry
task automatic alu_byte_block(input int op);
    logic [7:0]  a, b, c;
    logic [15:0] res;
    logic        cf;
    a  = 8'($random(seed));
    b  = 8'($random(seed));
    c  = 8'($random(seed));
    cf = 1'($random(seed));
    put(8'hB0); put(a);                   // MOV AL
    put(8'hB1); put(b);                   // MOV CL
    put(cf ? 8'hF9 : 8'hF8);
    ax[7:0] = a;
    flags[cpu_pkg::CF] = cf;
    put(8'(op << 3)); put(8'hC8);         // op AL, CL
    alu_model(op, 1'b0, {8'h00, a}, {8'h00, b}, flags, res);
    if (op != 7) ax[7:0] = res[7:0];
    put(8'hE6); put(8'h20);
    expect_write(16'h0020, ax[7:0]);
    put(8'((op << 3) | 4)); put(c);       // op AL, imm8
    alu_model(op, 1'b0, {8'h00, ax[7:0]}, {8'h00, c}, flags, res);
    if (op != 7) ax[7:0] = res[7:0];
    put(8'hE6); put(8'h21);
    expect_write(16'h0021, ax[7:0]);
    jcc_block(4'($random(seed)));
endtask

// ALU word immediate form with the result out on ports 30h and 31h
task automatic alu_word_block(input int op);
    logic [15:0] w, v, res;
    logic        cf;
    w  = 16'($random(seed));
    v  = 16'($random(seed));
    cf = 1'($random(seed));
    put(8'hB8); put(w[7:0]); put(w[15:8]);
    put(cf ? 8'hF9 : 8'hF8);
    ax = w;
    flags[cpu_pkg::CF] = cf;
    put(8'((op << 3) | 5)); put(v[7:0]); put(v[15:8]);
    alu_model(op, 1'b1, ax, v, flags, res);
    if (op != 7) ax = res;
    put(8'hE7); put(8'h30);
    expect_write(16'h0030, ax[7:0]);
    expect_write(16'h0031, ax[15:8]);
    jcc_block(4'($random(seed)));
endtask

// INC or DEC CX where CF must survive
task automatic incdec_block(input bit dec, input bit cf);
    logic [11:0] tmp;
    logic [15:0] res;
    put(cf ? 8'hF9 : 8'hF8);
    flags[cpu_pkg::CF] = cf;
    put(dec ? 8'h49 : 8'h41);
    tmp = flags;
    alu_model(dec ? 5 : 0, 1'b1, cx, 16'h0001, tmp, res);
    tmp[cpu_pkg::CF] = flags[cpu_pkg::CF];
    flags = tmp;
    cx    = res;
    jcc_block(4'h2);                      // JB shows the kept CF
    jcc_block(4'h4);                      // JE
endtask

task automatic build_program();
    logic [7:0]  a, b, c;
    logic [15:0] w, p, res;
    pc    = 0;
    flags = '0;
    ax    = '0;
    cx    = '0;
    // --------------------------------------------------
    // MOV into AL, AH, BX and BH
    // --------------------------------------------------
    a = 8'($random(seed));
    b = 8'($random(seed));
    put(8'hB0); put(a);
    put(8'hB4); put(b);
    put(8'hE7); put(8'h10);
    expect_write(16'h0010, a);
    expect_write(16'h0011, b);
    w = 16'($random(seed));
    c = 8'($random(seed));
    put(8'hBB); put(w[7:0]); put(w[15:8]);
    put(8'hB7); put(c);                   // MOV BH over BX high byte
    put(8'hB8); put(8'h00); put(8'h00);
    put(8'h09); put(8'hD8);               // OR AX, BX copies BX
    alu_model(1, 1'b1, 16'h0000, {c, w[7:0]}, flags, res);
    ax = res;
    put(8'hE7); put(8'h12);
    expect_write(16'h0012, w[7:0]);
    expect_write(16'h0013, c);
    // --------------------------------------------------
    // ALU operations
    // --------------------------------------------------
    for (int op = 0; op < 8; op++) alu_byte_block(op);
    for (int op = 0; op < 8; op++) alu_word_block(op);
    put(8'hB9); put(8'hFF); put(8'hFF);   // CX = FFFF
    cx = 16'hFFFF;
    // ALU carry differs from the kept CF in each block
    incdec_block(1'b0, 1'b0);
    incdec_block(1'b1, 1'b0);
    incdec_block(1'b1, 1'b1);
    // --------------------------------------------------
    // OUT through DX, then halt
    // --------------------------------------------------
    w = 16'($random(seed));
    p = 16'($random(seed));
    put(8'hB8); put(w[7:0]); put(w[15:8]);
    put(8'hBA); put(p[7:0]); put(p[15:8]);
    put(8'hEF);
    expect_write(p, w[7:0]);
    expect_write(p + 16'd1, w[15:8]);
    put(8'hEE);
    expect_write(p, w[7:0]);
    put(8'hF4);
    put(8'hE6); put(8'h50);               // Must never run
endtask

//--- sim/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

    logic        clock;
    logic        i_rst;
    logic [7:0]  i_data;
    logic [15:0] o_address;
    logic [15:0] o_port_address;
    logic [7:0]  o_port_data;
    logic        o_port_write;
    logic        o_halted;

    logic [7:0]  mem [0:65535];
    logic [15:0] exp_port [$];
    logic [7:0]  exp_data [$];
    logic [15:0] ax, cx;                  // Shadow registers
    logic [11:0] flags;
    integer      seed;
    int          pc;

    tb_clock tb_clock_inst (.o_clock(clock));

    cpu_top cpu_top_inst (
        .clock(clock), .i_rst(i_rst), .i_data(i_data), .o_address(o_address),
        .o_port_address(o_port_address), .o_port_data(o_port_data),
        .o_port_write(o_port_write), .o_halted(o_halted)
    );

    bind cpu_top cpu_sva cpu_sva_inst (
        .clock(clock), .i_rst(i_rst), .o_address(o_address),
        .o_port_address(o_port_address), .o_port_write(o_port_write), .o_halted(o_halted)
    );

    assign i_data = mem[o_address];       // Combinational program read

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic fail_value(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
        $display("TB FAILED");
        $fatal(1, "Wrong value on %s", name);
    endtask

    task automatic put(input logic [7:0] b);
        mem[pc] = b;
        pc++;
    endtask

    task automatic expect_write(input logic [15:0] port, input logic [7:0] data);
        exp_port.push_back(port);
        exp_data.push_back(data);
    endtask

    // 8086 arithmetic at 8 or 16 bits
    task automatic alu_model(input int op, input bit word, input logic [15:0] a, b,
                             inout logic [11:0] fl, output logic [15:0] res);
        int unsigned mask, ua, ub, cin, full;
        bit          sub, logic_op, sa, sbit, sr;
        mask = word ? 32'hFFFF : 32'hFF;
        ua   = {16'h0, a} & mask;
        ub   = {16'h0, b} & mask;
        cin  = (op == 2 || op == 3) ? {31'h0, fl[cpu_pkg::CF]} : 0;
        sub      = (op == 3 || op == 5 || op == 7);
        logic_op = (op == 1 || op == 4 || op == 6);
        case (op)
            1:       full = ua | ub;
            4:       full = ua & ub;
            6:       full = ua ^ ub;
            3, 5, 7: full = ua - ub - cin;
            default: full = ua + ub + cin;
        endcase
        res  = 16'(full & mask);
        sa   = word ? a[15] : a[7];
        sbit = word ? b[15] : b[7];
        sr   = word ? res[15] : res[7];
        if (logic_op) begin
            fl[cpu_pkg::CF] = 1'b0;
            fl[cpu_pkg::OF] = 1'b0;
        end else begin
            fl[cpu_pkg::CF] = sub ? (ub + cin > ua) : (full > mask);
            fl[cpu_pkg::AF] = a[4] ^ b[4] ^ res[4];
            fl[cpu_pkg::OF] = sub ? (sa != sbit) && (sr != sa) : (sa == sbit) && (sr != sa);
        end
        fl[cpu_pkg::SF] = sr;
        fl[cpu_pkg::ZF] = (res == 16'h0000);
        fl[cpu_pkg::PF] = ~^res[7:0];
    endtask

    // Jcc condition codes 70h..7Fh
    function automatic bit cond_true(input logic [3:0] cc, input logic [11:0] fl);
        bit c;
        case (cc[3:1])
            3'd0: c = fl[cpu_pkg::OF];
            3'd1: c = fl[cpu_pkg::CF];
            3'd2: c = fl[cpu_pkg::ZF];
            3'd3: c = fl[cpu_pkg::CF] | fl[cpu_pkg::ZF];
            3'd4: c = fl[cpu_pkg::SF];
            3'd5: c = fl[cpu_pkg::PF];
            3'd6: c = fl[cpu_pkg::SF] != fl[cpu_pkg::OF];
            default: c = (fl[cpu_pkg::SF] != fl[cpu_pkg::OF]) | fl[cpu_pkg::ZF];
        endcase
        return c ^ cc[0];
    endfunction

    `include "tb_program.svh"

    // Port writes in order against the queue
    always @(negedge clock) begin
        if (!i_rst && o_port_write) begin
            assert (exp_port.size() > 0)
                else stop_with_failure("Port write seen with none left to expect");
            assert (o_port_address == exp_port[0])
                else fail_value("o_port_address", exp_port[0], o_port_address);
            assert (o_port_data == exp_data[0])
                else fail_value("o_port_data", {8'h00, exp_data[0]}, {8'h00, o_port_data});
            void'(exp_port.pop_front());
            void'(exp_data.pop_front());
        end
    end

    initial begin
        int limit;
        int cycles;
        i_rst = 1'b1;
        seed  = 1;
        for (int i = 0; i < 65536; i++) mem[i] = 8'(i[7:0] ^ i[15:8]);
        build_program();
        limit  = 4 * pc + 50;
        cycles = 0;
        repeat (4) @(negedge clock);
        i_rst = 1'b0;
        while (!o_halted) begin
            @(negedge clock);
            cycles++;
            if (cycles >= limit) stop_with_failure("Timeout, core never halted");
        end
        repeat (5) @(negedge clock);   // Halted core must stay silent
        if (exp_port.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_with_failure($sformatf("%0d port writes never happened", exp_port.size()));
        end
    end

endmodule

//--- build.f
hw/cpu_pkg.sv
hw/cpu_alu.sv
hw/cpu_regfile.sv
hw/cpu_control.sv
hw/cpu_top.sv
sim/tb_clock.sv
sim/cpu_sva.sv
sim/tb_cpu.sv
+incdir+sim

//--- run.sh
#!/bin/bash
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_cpu \
    --Mdir obj_dir -o tb_cpu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_cpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1
